/* wbuf_cfg_pkg.sv */
/*
 * sizing constants of the coalescing write buffer
 * and the widths derived from them
 */

package wbuf_cfg_pkg;

  // byte address and data word
  localparam int ADDR_WIDTH  = 32;
  localparam int DATA_WIDTH  = 64;
  localparam int BE_WIDTH    = DATA_WIDTH / 8;

  // buffer entries and transaction slots
  localparam int WBUF_DEPTH  = 4;
  localparam int MAX_TX      = 2;

  // word address, the byte offset below it
  localparam int WTAG_WIDTH  = ADDR_WIDTH - 3;
  localparam int OFF_WIDTH   = ADDR_WIDTH - WTAG_WIDTH;

  // index widths
  localparam int PTR_WIDTH   = $clog2(WBUF_DEPTH);
  localparam int TX_ID_WIDTH = $clog2(MAX_TX);

  // 0 byte, 1 half, 2 word, 3 dword
  localparam int SIZE_WIDTH  = 2;

endpackage

/* wbuf_types_pkg.sv */
/*
 * packed structs of the write buffer: core and memory ports,
 * buffer entries and transaction slots
 */

package wbuf_types_pkg;

  // core write, taken when req and gnt are both high
  typedef struct packed {
    logic                                req;
    logic [wbuf_cfg_pkg::ADDR_WIDTH-1:0] addr;
    logic [wbuf_cfg_pkg::DATA_WIDTH-1:0] wdata;
    logic [wbuf_cfg_pkg::BE_WIDTH-1:0]   be;
  } core_wr_req_t;

  // aligned write towards memory, held until ack
  typedef struct packed {
    logic                                 req;
    logic [wbuf_cfg_pkg::ADDR_WIDTH-1:0]  paddr;
    logic [wbuf_cfg_pkg::DATA_WIDTH-1:0]  wdata;
    logic [wbuf_cfg_pkg::SIZE_WIDTH-1:0]  size;
    logic [wbuf_cfg_pkg::TX_ID_WIDTH-1:0] id;
  } mem_req_t;

  // write return carrying the slot id
  typedef struct packed {
    logic                                 vld;
    logic [wbuf_cfg_pkg::TX_ID_WIDTH-1:0] id;
  } mem_rtrn_t;

  // one buffered word
  // byte states valid/dirty/txblock: 000 free, 110 dirty, 101 in flight,
  // 111 rewritten while in flight
  typedef struct packed {
    logic [wbuf_cfg_pkg::WTAG_WIDTH-1:0] wtag;
    logic [wbuf_cfg_pkg::DATA_WIDTH-1:0] data;
    logic [wbuf_cfg_pkg::BE_WIDTH-1:0]   valid;
    logic [wbuf_cfg_pkg::BE_WIDTH-1:0]   dirty;
    logic [wbuf_cfg_pkg::BE_WIDTH-1:0]   txblock;
  } wbuf_entry_t;

  // one transaction in flight
  typedef struct packed {
    logic                               vld;
    logic [wbuf_cfg_pkg::PTR_WIDTH-1:0] ptr;
    logic [wbuf_cfg_pkg::BE_WIDTH-1:0]  be;
  } tx_slot_t;

endpackage

/* wbuf_size_encode.sv */
/*
 * request encoder: lowest dirty byte, largest aligned size,
 * byte enable and replicated write data
 */
`timescale 1ns/100ps

module wbuf_size_encode (
  input  wbuf_types_pkg::wbuf_entry_t               entry_i,
  input  logic [wbuf_cfg_pkg::BE_WIDTH-1:0]         dirty_mask_i,
  output logic [wbuf_cfg_pkg::ADDR_WIDTH-1:0]       paddr_o,
  output logic [wbuf_cfg_pkg::DATA_WIDTH-1:0]       wdata_o,
  output logic [wbuf_cfg_pkg::SIZE_WIDTH-1:0]       size_o,
  output logic [wbuf_cfg_pkg::BE_WIDTH-1:0]         be_o
);

  logic [wbuf_cfg_pkg::OFF_WIDTH-1:0]  off;
  logic [wbuf_cfg_pkg::BE_WIDTH-1:0]   mask_at_off;
  logic [wbuf_cfg_pkg::DATA_WIDTH-1:0] data_at_off;

  // offset of the lowest dirty byte
  always_comb begin : p_offset
    off = '0;
    for (int k = wbuf_cfg_pkg::BE_WIDTH - 1; k >= 0; k--) begin
      if (dirty_mask_i[k]) begin
        off = wbuf_cfg_pkg::OFF_WIDTH'(k);
      end
    end
  end

  // mask and data moved down so the offset byte sits at bit 0
  assign mask_at_off = dirty_mask_i >> off;
  assign data_at_off = entry_i.data >> {off, 3'b000};

  // largest size that is aligned at the offset and fully dirty
  // a split mask like 0011_1001 goes out as byte, byte, half
  always_comb begin : p_size
    if ((off == '0) && (&dirty_mask_i)) begin
      size_o = 2'd3;
    end else if ((off[1:0] == 2'b00) && (&mask_at_off[3:0])) begin
      size_o = 2'd2;
    end else if ((off[0] == 1'b0) && (&mask_at_off[1:0])) begin
      size_o = 2'd1;
    end else begin
      size_o = 2'd0;
    end
  end

  // byte enable of the transfer and data replicated across the dword
  always_comb begin : p_data
    unique case (size_o)
      2'd0: begin
        be_o    = wbuf_cfg_pkg::BE_WIDTH'(8'h01) << off;
        wdata_o = {8{data_at_off[7:0]}};
      end
      2'd1: begin
        be_o    = wbuf_cfg_pkg::BE_WIDTH'(8'h03) << off;
        wdata_o = {4{data_at_off[15:0]}};
      end
      2'd2: begin
        be_o    = wbuf_cfg_pkg::BE_WIDTH'(8'h0f) << off;
        wdata_o = {2{data_at_off[31:0]}};
      end
      default: begin
        be_o    = '1;
        wdata_o = entry_i.data;
      end
    endcase
  end

  // word address followed by the byte offset
  assign paddr_o = {entry_i.wtag, off};

endmodule

/* wbuf_rr_arb.sv */
/*
 * round-robin arbiter with lock-in
 * returns the index of the granted requester
 */
`timescale 1ns/100ps

module wbuf_rr_arb #(
  parameter  int NUM_IN    = 4,
  localparam int IDX_WIDTH = (NUM_IN > 1) ? $clog2(NUM_IN) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [NUM_IN-1:0]    req_i,
  input  logic                 gnt_i,
  output logic [IDX_WIDTH-1:0] idx_o,
  output logic                 vld_o
);

  localparam logic [IDX_WIDTH-1:0] LAST_IDX = IDX_WIDTH'(NUM_IN - 1);

  logic [IDX_WIDTH-1:0] rr_q;
  logic [IDX_WIDTH-1:0] idx_q;
  logic [IDX_WIDTH-1:0] pick;
  logic                 lock_q;
  logic                 locked;

  // first requester at or after the round-robin pointer
  always_comb begin : p_pick
    logic [IDX_WIDTH-1:0] cand;
    logic                 found;
    pick  = rr_q;
    cand  = rr_q;
    found = 1'b0;
    for (int i = 0; i < NUM_IN; i++) begin
      if (!found && req_i[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
      cand = (cand == LAST_IDX) ? '0 : cand + 1'b1;
    end
  end

  // keep the previous choice while it still requests and was not consumed
  assign locked = lock_q && req_i[idx_q];
  assign idx_o  = locked ? idx_q : pick;
  assign vld_o  = |req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      rr_q   <= '0;
      idx_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= vld_o && !gnt_i;
      idx_q  <= idx_o;
      // priority moves past the consumed requester
      if (gnt_i) begin
        rr_q <= (idx_o == LAST_IDX) ? '0 : idx_o + 1'b1;
      end
    end
  end

endmodule

/* wbuf_tx_tracker.sv */
/*
 * transaction tracking: slot table, free slot choice,
 * return id queue and the eviction of returned words
 */
`timescale 1ns/100ps

module wbuf_tx_tracker (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      mem_fire_i,
  input  logic [wbuf_cfg_pkg::BE_WIDTH-1:0]         tx_be_i,
  input  logic [wbuf_cfg_pkg::PTR_WIDTH-1:0]        dirty_ptr_i,
  input  wbuf_types_pkg::wbuf_entry_t [wbuf_cfg_pkg::WBUF_DEPTH-1:0] entries_i,
  input  wbuf_types_pkg::mem_rtrn_t                 mem_rtrn_i,
  output logic [wbuf_cfg_pkg::TX_ID_WIDTH-1:0]      tx_id_o,
  output logic                                      tx_free_o,
  output logic                                      evict_o,
  output logic [wbuf_cfg_pkg::PTR_WIDTH-1:0]        rtrn_ptr_o,
  output logic [wbuf_cfg_pkg::BE_WIDTH-1:0]         rtrn_be_o
);

  localparam logic [wbuf_cfg_pkg::TX_ID_WIDTH-1:0] Q_LAST =
    wbuf_cfg_pkg::TX_ID_WIDTH'(wbuf_cfg_pkg::MAX_TX - 1);

  wbuf_types_pkg::tx_slot_t [wbuf_cfg_pkg::MAX_TX-1:0] slots_d;
  wbuf_types_pkg::tx_slot_t [wbuf_cfg_pkg::MAX_TX-1:0] slots_q;
  logic [wbuf_cfg_pkg::MAX_TX-1:0]        slot_busy;

  // return queue, one place per slot so it cannot overflow
  logic [wbuf_cfg_pkg::TX_ID_WIDTH-1:0]   q_mem [wbuf_cfg_pkg::MAX_TX];
  logic [wbuf_cfg_pkg::TX_ID_WIDTH-1:0]   q_wr_q;
  logic [wbuf_cfg_pkg::TX_ID_WIDTH-1:0]   q_rd_q;
  logic [wbuf_cfg_pkg::TX_ID_WIDTH:0]     q_cnt_q;
  logic [wbuf_cfg_pkg::TX_ID_WIDTH-1:0]   rtrn_id;
  logic                                   q_push;

  //////////////////////////////////////////////////////////////////////
  // free slot choice
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < wbuf_cfg_pkg::MAX_TX; k++) begin : gen_busy
    assign slot_busy[k] = slots_q[k].vld;
  end

  // locks like the dirty arbiter so the id stays stable until ack
  wbuf_rr_arb #(
    .NUM_IN ( wbuf_cfg_pkg::MAX_TX )
  ) i_slot_arb (
    .clk_i  ( clk_i      ),
    .rst_ni ( rst_ni     ),
    .req_i  ( ~slot_busy ),
    .gnt_i  ( mem_fire_i ),
    .idx_o  ( tx_id_o    ),
    .vld_o  ( tx_free_o  )
  );

  //////////////////////////////////////////////////////////////////////
  // return queue and eviction
  //////////////////////////////////////////////////////////////////////

  assign q_push  = mem_rtrn_i.vld;
  assign evict_o = (q_cnt_q != '0);
  assign rtrn_id = q_mem[q_rd_q];

  // no cache update, so the head always evicts in the cycle it leaves
  assign rtrn_ptr_o = slots_q[rtrn_id].ptr;
  // only bytes not rewritten during the flight are clean
  assign rtrn_be_o  = slots_q[rtrn_id].be & ~entries_i[rtrn_ptr_o].dirty;

  always_ff @(posedge clk_i) begin : p_q_mem
    if (q_push) begin
      q_mem[q_wr_q] <= mem_rtrn_i.id;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // slot table
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_slots
    slots_d = slots_q;
    if (evict_o) begin
      slots_d[rtrn_id].vld = 1'b0;
    end
    // the chosen slot was free, so it never collides with the evicted one
    if (mem_fire_i) begin
      slots_d[tx_id_o].vld = 1'b1;
      slots_d[tx_id_o].ptr = dirty_ptr_i;
      slots_d[tx_id_o].be  = tx_be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      slots_q <= '0;
      q_wr_q  <= '0;
      q_rd_q  <= '0;
      q_cnt_q <= '0;
    end else begin
      slots_q <= slots_d;
      if (q_push) begin
        q_wr_q <= (q_wr_q == Q_LAST) ? '0 : q_wr_q + 1'b1;
      end
      if (evict_o) begin
        q_rd_q <= (q_rd_q == Q_LAST) ? '0 : q_rd_q + 1'b1;
      end
      q_cnt_q <= q_cnt_q + q_push - evict_o;
    end
  end

endmodule

/* wbuf_store.sv */
/*
 * entry array of the write buffer: hit and free search, coalescing write,
 * choice of the dirty entry to send and the byte state updates
 */
`timescale 1ns/100ps

module wbuf_store (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  wbuf_types_pkg::core_wr_req_t              core_req_i,
  output logic                                      core_gnt_o,
  input  logic [wbuf_cfg_pkg::BE_WIDTH-1:0]         tx_be_i,
  input  logic                                      mem_fire_i,
  input  logic                                      evict_i,
  input  logic [wbuf_cfg_pkg::PTR_WIDTH-1:0]        rtrn_ptr_i,
  input  logic [wbuf_cfg_pkg::BE_WIDTH-1:0]         rtrn_be_i,
  input  logic                                      tx_free_i,
  output wbuf_types_pkg::wbuf_entry_t [wbuf_cfg_pkg::WBUF_DEPTH-1:0] entries_o,
  output wbuf_types_pkg::wbuf_entry_t               dirty_entry_o,
  output logic [wbuf_cfg_pkg::PTR_WIDTH-1:0]        dirty_ptr_o,
  output logic                                      dirty_req_o,
  output logic                                      empty_o
);

  wbuf_types_pkg::wbuf_entry_t [wbuf_cfg_pkg::WBUF_DEPTH-1:0] entries_d;
  wbuf_types_pkg::wbuf_entry_t [wbuf_cfg_pkg::WBUF_DEPTH-1:0] entries_q;

  logic [wbuf_cfg_pkg::WBUF_DEPTH-1:0] valid;
  logic [wbuf_cfg_pkg::WBUF_DEPTH-1:0] hit_oh;
  logic [wbuf_cfg_pkg::WBUF_DEPTH-1:0] eligible;
  logic [wbuf_cfg_pkg::PTR_WIDTH-1:0]  hit_ptr;
  logic [wbuf_cfg_pkg::PTR_WIDTH-1:0]  free_ptr;
  logic [wbuf_cfg_pkg::PTR_WIDTH-1:0]  wr_ptr;
  logic [wbuf_cfg_pkg::PTR_WIDTH-1:0]  wr_ptr_q;
  logic [wbuf_cfg_pkg::WTAG_WIDTH-1:0] req_wtag;
  logic                                wr_vld_q;
  logic                                hit;
  logic                                full;
  logic                                dirty_vld;
  logic                                busy_hit;

  //////////////////////////////////////////////////////////////////////
  // per entry flags and search
  //////////////////////////////////////////////////////////////////////

  assign req_wtag = core_req_i.addr[wbuf_cfg_pkg::ADDR_WIDTH-1:wbuf_cfg_pkg::OFF_WIDTH];

  for (genvar k = 0; k < wbuf_cfg_pkg::WBUF_DEPTH; k++) begin : gen_flags
    assign valid[k]  = |entries_q[k].valid;
    assign hit_oh[k] = valid[k] && (entries_q[k].wtag == req_wtag);
    // dirty bytes, none in flight since transactions may overtake each other
    // a word written last cycle waits one more so back-to-back writes merge
    assign eligible[k] = (|(entries_q[k].dirty & entries_q[k].valid)) &&
                         !(|entries_q[k].txblock) &&
                         !(wr_vld_q && (wr_ptr_q == wbuf_cfg_pkg::PTR_WIDTH'(k)));
  end

  // lowest hit and lowest free entry
  always_comb begin : p_search
    hit_ptr  = '0;
    free_ptr = '0;
    full     = 1'b1;
    for (int k = wbuf_cfg_pkg::WBUF_DEPTH - 1; k >= 0; k--) begin
      if (hit_oh[k]) begin
        hit_ptr = wbuf_cfg_pkg::PTR_WIDTH'(k);
      end
      if (!valid[k]) begin
        free_ptr = wbuf_cfg_pkg::PTR_WIDTH'(k);
        full     = 1'b0;
      end
    end
  end

  assign hit    = |hit_oh;
  assign wr_ptr = hit ? hit_ptr : free_ptr;

  //////////////////////////////////////////////////////////////////////
  // dirty entry selection and core grant
  //////////////////////////////////////////////////////////////////////

  wbuf_rr_arb #(
    .NUM_IN ( wbuf_cfg_pkg::WBUF_DEPTH )
  ) i_dirty_arb (
    .clk_i  ( clk_i       ),
    .rst_ni ( rst_ni      ),
    .req_i  ( eligible    ),
    .gnt_i  ( mem_fire_i  ),
    .idx_o  ( dirty_ptr_o ),
    .vld_o  ( dirty_vld   )
  );

  assign dirty_req_o   = dirty_vld && tx_free_i;
  assign dirty_entry_o = entries_q[dirty_ptr_o];
  assign entries_o     = entries_q;
  assign empty_o       = ~(|valid);

  // the word on the memory bus must not change before its ack
  assign busy_hit   = hit && dirty_req_o && !mem_fire_i && (hit_ptr == dirty_ptr_o);
  assign core_gnt_o = core_req_i.req && (hit || !full) && !busy_hit;

  //////////////////////////////////////////////////////////////////////
  // byte state update
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_update
    entries_d = entries_q;

    // one transaction per entry at a time, so the whole txblock clears
    // clean returned bytes leave, rewritten ones stay dirty for a resend
    if (evict_i) begin
      entries_d[rtrn_ptr_i].txblock = '0;
      entries_d[rtrn_ptr_i].valid   = entries_q[rtrn_ptr_i].valid & ~rtrn_be_i;
    end

    // sent bytes become clean and in flight
    if (mem_fire_i) begin
      entries_d[dirty_ptr_o].dirty   = entries_q[dirty_ptr_o].dirty & ~tx_be_i;
      entries_d[dirty_ptr_o].txblock = entries_q[dirty_ptr_o].txblock | tx_be_i;
    end

    // merge the enabled bytes of the core write
    if (core_gnt_o) begin
      entries_d[wr_ptr].wtag = req_wtag;
      for (int k = 0; k < wbuf_cfg_pkg::BE_WIDTH; k++) begin
        if (core_req_i.be[k]) begin
          entries_d[wr_ptr].valid[k]       = 1'b1;
          entries_d[wr_ptr].dirty[k]       = 1'b1;
          entries_d[wr_ptr].data[k*8 +: 8] = core_req_i.wdata[k*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      entries_q <= '0;
      wr_vld_q  <= 1'b0;
      wr_ptr_q  <= '0;
    end else begin
      entries_q <= entries_d;
      wr_vld_q  <= core_gnt_o;
      wr_ptr_q  <= wr_ptr;
    end
  end

endmodule

/* wbuf_top.sv */
/*
 * coalescing write buffer top level
 * entry store, request encoder and transaction tracker
 */
`timescale 1ns/100ps

module wbuf_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  wbuf_types_pkg::core_wr_req_t core_req_i,
  output logic                         core_gnt_o,
  output wbuf_types_pkg::mem_req_t     mem_req_o,
  input  logic                         mem_ack_i,
  input  wbuf_types_pkg::mem_rtrn_t    mem_rtrn_i,
  output logic                         empty_o
);

  wbuf_types_pkg::wbuf_entry_t [wbuf_cfg_pkg::WBUF_DEPTH-1:0] entries;
  wbuf_types_pkg::wbuf_entry_t          dirty_entry;
  logic [wbuf_cfg_pkg::PTR_WIDTH-1:0]   dirty_ptr;
  logic [wbuf_cfg_pkg::PTR_WIDTH-1:0]   rtrn_ptr;
  logic [wbuf_cfg_pkg::BE_WIDTH-1:0]    tx_be;
  logic [wbuf_cfg_pkg::BE_WIDTH-1:0]    rtrn_be;
  logic [wbuf_cfg_pkg::TX_ID_WIDTH-1:0] tx_id;
  logic [wbuf_cfg_pkg::ADDR_WIDTH-1:0]  paddr;
  logic [wbuf_cfg_pkg::DATA_WIDTH-1:0]  wdata;
  logic [wbuf_cfg_pkg::SIZE_WIDTH-1:0]  size;
  logic                                 dirty_req;
  logic                                 mem_fire;
  logic                                 evict;
  logic                                 tx_free;

  // request accepted by memory
  assign mem_fire = dirty_req && mem_ack_i;

  assign mem_req_o.req   = dirty_req;
  assign mem_req_o.paddr = paddr;
  assign mem_req_o.wdata = wdata;
  assign mem_req_o.size  = size;
  assign mem_req_o.id    = tx_id;

  wbuf_store i_store (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .core_req_i    ( core_req_i  ),
    .core_gnt_o    ( core_gnt_o  ),
    .tx_be_i       ( tx_be       ),
    .mem_fire_i    ( mem_fire    ),
    .evict_i       ( evict       ),
    .rtrn_ptr_i    ( rtrn_ptr    ),
    .rtrn_be_i     ( rtrn_be     ),
    .tx_free_i     ( tx_free     ),
    .entries_o     ( entries     ),
    .dirty_entry_o ( dirty_entry ),
    .dirty_ptr_o   ( dirty_ptr   ),
    .dirty_req_o   ( dirty_req   ),
    .empty_o       ( empty_o     )
  );

  wbuf_size_encode i_encode (
    .entry_i      ( dirty_entry       ),
    .dirty_mask_i ( dirty_entry.dirty ),
    .paddr_o      ( paddr             ),
    .wdata_o      ( wdata             ),
    .size_o       ( size              ),
    .be_o         ( tx_be             )
  );

  wbuf_tx_tracker i_tracker (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .mem_fire_i  ( mem_fire   ),
    .tx_be_i     ( tx_be      ),
    .dirty_ptr_i ( dirty_ptr  ),
    .entries_i   ( entries    ),
    .mem_rtrn_i  ( mem_rtrn_i ),
    .tx_id_o     ( tx_id      ),
    .tx_free_o   ( tx_free    ),
    .evict_o     ( evict      ),
    .rtrn_ptr_o  ( rtrn_ptr   ),
    .rtrn_be_o   ( rtrn_be    )
  );

endmodule

/* wbuf_checker.sv */
/*
 * protocol assertions of the write buffer ports
 * bound into wbuf_top
 */
`timescale 1ns/100ps

module wbuf_checker (
  input logic                         clk_i,
  input logic                         rst_ni,
  input wbuf_types_pkg::core_wr_req_t core_req_i,
  input logic                         core_gnt_o,
  input wbuf_types_pkg::mem_req_t     mem_req_o,
  input logic                         mem_ack_i,
  input wbuf_types_pkg::mem_rtrn_t    mem_rtrn_i
);

  // ids handed out and not yet returned
  logic [wbuf_cfg_pkg::MAX_TX-1:0] busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_busy
    if (!rst_ni) begin
      busy_q <= '0;
    end else begin
      if (mem_rtrn_i.vld) begin
        busy_q[mem_rtrn_i.id] <= 1'b0;
      end
      if (mem_req_o.req && mem_ack_i) begin
        busy_q[mem_req_o.id] <= 1'b1;
      end
    end
  end

  a_gnt_needs_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_gnt_o |-> core_req_i.req)
    else $error("core grant without a core request");

  // all request fields frozen while memory stalls
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o.req && !mem_ack_i) |=> $stable(mem_req_o))
    else $error("memory request changed before its acknowledge");

  a_slot_limit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (&busy_q) |-> !mem_req_o.req)
    else $error("memory request while every transaction slot is busy");

  a_fresh_id : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.req |-> !busy_q[mem_req_o.id])
    else $error("memory request reuses an id that is still in flight");

endmodule

bind wbuf_top wbuf_checker i_checker (
  .clk_i      ( clk_i      ),
  .rst_ni     ( rst_ni     ),
  .core_req_i ( core_req_i ),
  .core_gnt_o ( core_gnt_o ),
  .mem_req_o  ( mem_req_o  ),
  .mem_ack_i  ( mem_ack_i  ),
  .mem_rtrn_i ( mem_rtrn_i )
);

/* wbuf_tb.sv */
/*
 * testbench of the write buffer: clock, reset, core stimulus,
 * memory responder, expected request scoreboard and watchdog
 */
`timescale 1ns/100ps

module wbuf_tb;

  localparam int CLK_NS      = 8;
  localparam int TEST_CYCLES = 300;
  localparam int NUM_TESTS   = 6;
  localparam int WATCHDOG_NS = NUM_TESTS * TEST_CYCLES * CLK_NS * 2;

  typedef struct packed {
    logic [wbuf_cfg_pkg::ADDR_WIDTH-1:0] paddr;
    logic [wbuf_cfg_pkg::SIZE_WIDTH-1:0] size;
    logic [wbuf_cfg_pkg::DATA_WIDTH-1:0] wdata;
  } exp_req_t;

  logic                         clk_i;
  logic                         rst_ni     = 1'b0;
  logic                         mem_ack_i  = 1'b0;
  logic                         core_gnt_o;
  logic                         empty_o;
  wbuf_types_pkg::core_wr_req_t core_req_i = '0;
  wbuf_types_pkg::mem_rtrn_t    mem_rtrn_i = '0;
  wbuf_types_pkg::mem_req_t     mem_req_o;

  exp_req_t                                 exp_q [$];
  logic [wbuf_cfg_pkg::TX_ID_WIDTH-1:0]     pend_id [$];
  logic [wbuf_cfg_pkg::TX_ID_WIDTH-1:0]     ids_seen [$];
  int                                       pend_t [$];
  int     cyc = 0;
  int     err_cnt = 0;
  int     test_err = 0;
  int     tests_failed = 0;
  int     tests_run = 0;
  integer seed = 82414;
  string  test_name = "reset";
  // responder knobs
  logic   ack_en = 1'b0;
  logic   rtrn_en = 1'b0;
  logic   rtrn_rev = 1'b0;
  int     rtrn_dly = 2;

  wbuf_top dut_i (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // memory side: ack on the falling edge, returns after a delay
  ////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : responder
    mem_ack_i  = ack_en;
    mem_rtrn_i = '0;
    if (rtrn_en && (pend_id.size() > 0)) begin
      if (rtrn_rev && (cyc >= pend_t[$] + rtrn_dly)) begin
        mem_rtrn_i.vld = 1'b1;
        mem_rtrn_i.id  = pend_id.pop_back();
        void'(pend_t.pop_back());
      end else if (!rtrn_rev && (cyc >= pend_t[0] + rtrn_dly)) begin
        mem_rtrn_i.vld = 1'b1;
        mem_rtrn_i.id  = pend_id.pop_front();
        void'(pend_t.pop_front());
      end
    end
  end

  // accepted requests are matched against the oldest expected request of their word
  // so the pieces of one word must come out in the expected order
  always @(posedge clk_i) begin : monitor
    int    idx;
    string exp_s;
    string act_s;
    cyc = cyc + 1;
    if (rst_ni && mem_req_o.req && mem_ack_i) begin
      pend_id.push_back(mem_req_o.id);
      pend_t.push_back(cyc);
      ids_seen.push_back(mem_req_o.id);
      idx = -1;
      foreach (exp_q[i]) begin
        if ((idx < 0) && (exp_q[i].paddr[31:3] == mem_req_o.paddr[31:3])) begin
          idx = i;
        end
      end
      assert (idx >= 0) else begin
        $display("test %s: unexpected memory request at paddr %h", test_name, mem_req_o.paddr);
        err_cnt++;
      end
      if (idx >= 0) begin
        assert ((exp_q[idx].paddr == mem_req_o.paddr) && (exp_q[idx].size == mem_req_o.size) &&
                (exp_q[idx].wdata == mem_req_o.wdata))
        else begin
          exp_s = $sformatf("paddr %h size %0d data %h", exp_q[idx].paddr, exp_q[idx].size,
                            exp_q[idx].wdata);
          act_s = $sformatf("paddr %h size %0d data %h", mem_req_o.paddr, mem_req_o.size,
                            mem_req_o.wdata);
          $display("CHECK FAILED %s: expected %s, actual %s", test_name, exp_s, act_s);
          err_cnt++;
        end
        exp_q.delete(idx);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////

  // split a dirty mask into aligned requests, lowest byte first
  task automatic expect_requests(input logic [31:0] addr, input logic [7:0] mask,
                                 input logic [63:0] data);
    logic [7:0] left;
    int         off;
    int         nb;
    exp_req_t   e;
    left = mask;
    while (left != 8'h00) begin
      off = 0;
      while (!left[off]) begin
        off++;
      end
      nb = 8;
      while (((off % nb) != 0) ||
             (((int'(left) >> off) & ((1 << nb) - 1)) != ((1 << nb) - 1))) begin
        nb = nb / 2;
      end
      for (int i = 0; i < 8; i++) begin
        e.wdata[i*8 +: 8] = data[(off + (i % nb))*8 +: 8];
      end
      e.paddr = {addr[31:3], 3'(off)};
      e.size  = 2'($clog2(nb));
      exp_q.push_back(e);
      left = left & ~8'(((1 << nb) - 1) << off);
    end
  endtask

  // present a write from a falling edge, sample grant just before the rising edge
  task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] be, input int limit, output logic granted);
    int n;
    n       = 0;
    granted = 1'b0;
    core_req_i = {1'b1, addr, data, be};
    while (!granted && (n < limit)) begin
      #(CLK_NS / 2 - 1);
      granted = core_gnt_o;
      @(negedge clk_i);
      n++;
    end
    core_req_i.req = 1'b0;
  endtask

  task automatic write_ok(input logic [31:0] addr, input logic [63:0] data, input logic [7:0] be);
    logic g;
    write_word(addr, data, be, 50, g);
    assert (g) else begin
      $display("test %s: write to %h was never granted", test_name, addr);
      err_cnt++;
    end
  endtask

  // memory request must stay low for n cycles
  task automatic expect_quiet(input int n);
    repeat (n) begin
      #(CLK_NS / 2 - 1);
      assert (!mem_req_o.req) else begin
        $display("test %s: memory request raised while it must stay low", test_name);
        err_cnt++;
      end
      @(negedge clk_i);
    end
  endtask

  task automatic wait_left(input int left_cnt);
    int n;
    n = 0;
    while ((exp_q.size() > left_cnt) && (n < TEST_CYCLES)) begin
      @(negedge clk_i);
      n++;
    end
    assert (exp_q.size() <= left_cnt) else begin
      $display("test %s: expected memory requests did not arrive", test_name);
      err_cnt++;
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (((exp_q.size() > 0) || (pend_id.size() > 0) || !empty_o) && (n < TEST_CYCLES)) begin
      @(negedge clk_i);
      n++;
    end
    assert (empty_o && (exp_q.size() == 0)) else begin
      $display("test %s: buffer did not drain", test_name);
      err_cnt++;
    end
    exp_q.delete();
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err  = err_cnt;
    ack_en    = 1'b1;
    rtrn_en   = 1'b1;
    rtrn_rev  = 1'b0;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_cnt != test_err) begin
      tests_failed++;
    end
    $display("test %s: %s", test_name, (err_cnt == test_err) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [63:0] d [4];
    logic [63:0] h;
    logic        g;
    int          k;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    assert (empty_o && !core_gnt_o && !mem_req_o.req) else begin
      $display("outputs not idle after reset");
      err_cnt++;
    end

    start_test("full_dword");
    d[0] = {$random(seed), $random(seed)};
    expect_requests(32'h1000, 8'hff, d[0]);
    write_ok(32'h1000, d[0], 8'hff);
    assert (!empty_o) else begin
      $display("test %s: buffer still empty after a granted write", test_name);
      err_cnt++;
    end
    wait_drained();
    end_test();

    start_test("coalescing");
    ack_en = 1'b0;
    d[0] = {$random(seed), $random(seed)};
    d[1] = {$random(seed), $random(seed)};
    expect_requests(32'h2008, 8'hff, {d[1][63:32], d[0][31:0]});
    write_ok(32'h2008, d[0], 8'h0f);
    write_ok(32'h2008, d[1], 8'hf0);
    repeat (4) @(negedge clk_i);
    ack_en = 1'b1;
    wait_drained();
    end_test();

    start_test("split_mask");
    d[0] = {$random(seed), $random(seed)};
    expect_requests(32'h2100, 8'b0011_1001, d[0]);
    write_ok(32'h2100, d[0], 8'b0011_1001);
    wait_drained();
    end_test();

    start_test("rewrite_in_flight");
    rtrn_en = 1'b0;
    d[0] = {$random(seed), $random(seed)};
    d[1] = {$random(seed), $random(seed)};
    expect_requests(32'h2200, 8'hff, d[0]);
    write_ok(32'h2200, d[0], 8'hff);
    wait_left(0);
    write_ok(32'h2200, d[1], 8'h0f);
    expect_quiet(10);
    expect_requests(32'h2200, 8'h0f, d[1]);
    rtrn_en = 1'b1;
    wait_drained();
    end_test();

    start_test("full_buffer");
    ack_en = 1'b0;
    for (int i = 0; i < wbuf_cfg_pkg::WBUF_DEPTH; i++) begin
      d[i] = {$random(seed), $random(seed)};
      write_ok(32'h3000 + 32'(i * 8), d[i], 8'hff);
    end
    write_word(32'h4000, 64'h0, 8'hff, 6, g);
    assert (!g) else begin
      $display("test %s: write to a new word granted while the buffer is full", test_name);
      err_cnt++;
    end
    // hit a word that is not the one held on the memory bus
    k = 0;
    while ((32'h3000 + 32'(k * 8)) == {mem_req_o.paddr[31:3], 3'b000}) begin
      k++;
    end
    h = {$random(seed), $random(seed)};
    write_ok(32'h3000 + 32'(k * 8), h, 8'h01);
    d[k][7:0] = h[7:0];
    for (int i = 0; i < wbuf_cfg_pkg::WBUF_DEPTH; i++) begin
      expect_requests(32'h3000 + 32'(i * 8), 8'hff, d[i]);
    end
    ack_en = 1'b1;
    wait_drained();
    end_test();

    start_test("slot_limit");
    rtrn_en = 1'b0;
    ids_seen.delete();
    for (int i = 0; i < 3; i++) begin
      d[i] = {$random(seed), $random(seed)};
      expect_requests(32'h5000 + 32'(i * 8), 8'hff, d[i]);
      write_ok(32'h5000 + 32'(i * 8), d[i], 8'hff);
    end
    wait_left(1);
    expect_quiet(8);
    assert ((ids_seen.size() == 2) && (ids_seen[0] != ids_seen[1])) else begin
      $display("test %s: in-flight transactions do not carry two distinct ids", test_name);
      err_cnt++;
    end
    rtrn_rev = 1'b1;
    rtrn_en  = 1'b1;
    wait_drained();
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* wbuf.f */
wbuf_cfg_pkg.sv
wbuf_types_pkg.sv
wbuf_size_encode.sv
wbuf_rr_arb.sv
wbuf_tx_tracker.sv
wbuf_store.sv
wbuf_top.sv
wbuf_checker.sv
wbuf_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the write buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module wbuf_tb -f wbuf.f -o sim_wbuf

./obj_dir/sim_wbuf > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
